// ==== common/loader_cfg.svh ====
`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// download bus widths
`define LDR_ADDR_W      27
`define LDR_DATA_W      8
`define LDR_INDEX_W     16

// sdram and prom widths
`define SDR_ADDR_W      22
`define SDR_DATA_W      16
`define PROM_ADDR_W     14

// ioctl indices
`define IDX_ROM         16'd0
`define IDX_DIPSW       16'd254

// region codes, addr[19:16]
`define REGION_BOOT     4'd4
`define REGION_PROM     4'd5

// boot rom lands right after the game program in bank 0
`define BOOT_SDR_BASE   22'h02_0000

// switch power-on values
`define DIPSW1_DEF      8'hFF
`define DIPSW2_DEF      8'h42
`define DIPSW3_DEF      8'hFF
`define CORECFG_DEF     8'h00

`endif

// ==== common/loader_pkg.sv ====
`include "loader_cfg.svh"

package loader_pkg;

    // one masked program write toward the sdram controller
    typedef struct packed {
        logic [`SDR_ADDR_W-1:0] addr;
        logic [`SDR_DATA_W-1:0] data;
        logic [1:0]             mask;
        logic [1:0]             bank;
    } sdram_prog_t;

    // one-hot chip select of the on-chip proms
    typedef enum logic [2:0] {
        PROM_NONE  = 3'b000,
        PROM_SND   = 3'b001,
        PROM_WAVE1 = 3'b010,
        PROM_WAVE2 = 3'b100
    } prom_sel_e;

    // addr[19:16] of a rom download, codes 6 and up are unused
    typedef enum logic [3:0] {
        RGN_PROG0 = 4'd0,
        RGN_PROG1 = 4'd1,
        RGN_PROG2 = 4'd2,
        RGN_PROG3 = 4'd3,
        RGN_BOOT  = `REGION_BOOT,
        RGN_PROM  = `REGION_PROM
    } region_e;

endpackage

// ==== common/input_pkg.sv ====
package input_pkg;

    // active-low board inputs, in0 in the low byte
    typedef struct packed {
        logic [7:0] in2;
        logic [7:0] in1;
        logic [7:0] in0;
    } board_in_t;

    // switch byte picked by addr[2:0] of index 254
    typedef enum logic [1:0] {
        DIP_SW1     = 2'd0,
        DIP_SW2     = 2'd1,
        DIP_SW3     = 2'd2,
        DIP_CORECFG = 2'd3
    } dipsw_sel_e;

endpackage

// ==== common/ioctl_if.sv ====
`timescale 1ns/1ps
`include "loader_cfg.svh"

interface ioctl_if;

    logic [`LDR_INDEX_W-1:0] index;
    logic [`LDR_ADDR_W-1:0]  addr;
    logic [`LDR_DATA_W-1:0]  data;
    logic                    wr;

    // decode side sees the strobe, the ports only see the payload
    modport ctrl (input index, input addr, input wr);
    modport port (input addr, input data);

endinterface

// ==== loader/loader_ctrl.sv ====
`timescale 1ns/1ps
`include "loader_cfg.svh"

module loader_ctrl (
    input  logic     i_EMU_MCLK,
    input  logic     i_EMU_INITRST,
    ioctl_if.ctrl    ioctl,
    input  logic     i_soft_rst,
    input  logic     i_sdram_init,
    input  logic     i_sdram_busy,
    output logic     o_sdram_load,
    output logic     o_prom_load,
    output logic     o_dip_load,
    output logic     o_ioctl_wait,
    output logic     o_game_rst
);

    logic                 dl_done;
    logic                 accept;
    logic                 is_rom;
    logic                 is_dip;
    logic                 dip_sel_ok;
    loader_pkg::region_e  region;

    //////////////////////////////////////////////////
    // download state

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST) begin
            dl_done <= 1'b0;
        end else if (is_dip) begin
            // first sight of the switch index ends the rom download
            dl_done <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // dispatch

    assign o_ioctl_wait = i_sdram_init | i_sdram_busy;

    // stream is held by the host while wait is up
    assign accept = ioctl.wr & ~o_ioctl_wait;

    assign region     = loader_pkg::region_e'(ioctl.addr[19:16]);
    assign is_rom     = (ioctl.index == `IDX_ROM) & ~dl_done;
    assign is_dip     = (ioctl.index == `IDX_DIPSW);
    // selectors 4..7 name no switch byte
    assign dip_sel_ok = (ioctl.addr[2:0] <= 3'(input_pkg::DIP_CORECFG));

    assign o_sdram_load = accept & is_rom & (region <= loader_pkg::RGN_BOOT);
    assign o_prom_load  = accept & is_rom & (region == loader_pkg::RGN_PROM);
    assign o_dip_load   = accept & is_dip & dl_done & dip_sel_ok;

    // board stays in reset until the rom image is complete
    assign o_game_rst = ~dl_done | i_soft_rst;

endmodule

// ==== loader/sdram_prog_port.sv ====
`timescale 1ns/1ps
`include "loader_cfg.svh"

module sdram_prog_port (
    input  logic                     i_EMU_MCLK,
    input  logic                     i_EMU_INITRST,
    ioctl_if.port                    ioctl,
    input  logic                     i_load,
    input  logic                     i_prog_ack,
    output loader_pkg::sdram_prog_t  o_prog,
    output logic                     o_prog_req,
    output logic                     o_busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_ACK_LOW
    } hs_state_e;

    hs_state_e                st;
    loader_pkg::sdram_prog_t  prog_next;
    loader_pkg::region_e      region;

    assign region = loader_pkg::region_e'(ioctl.addr[19:16]);

    //////////////////////////////////////////////////
    // address map and byte staging

    always_comb begin
        prog_next.data = {ioctl.data, ioctl.data};
        prog_next.bank = 2'd0;
        if (region == loader_pkg::RGN_BOOT) begin
            prog_next.addr = `BOOT_SDR_BASE + `SDR_ADDR_W'(ioctl.addr[14:0]);
            prog_next.mask = ioctl.addr[15] ? 2'b10 : 2'b01;
        end else begin
            // even rom on the high byte, odd rom on the low byte
            prog_next.addr = `SDR_ADDR_W'(ioctl.addr[16:0]);
            prog_next.mask = ioctl.addr[17] ? 2'b10 : 2'b01;
        end
    end

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_load) begin
            o_prog <= prog_next;
        end
    end

    //////////////////////////////////////////////////
    // four-phase req/ack

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST) begin
            st <= ST_IDLE;
        end else begin
            case (st)
                ST_IDLE:    if (i_load) st <= ST_REQ;
                ST_REQ:     if (i_prog_ack) st <= ST_ACK_LOW;
                ST_ACK_LOW: if (!i_prog_ack) st <= ST_IDLE;
                default:    st <= ST_IDLE;
            endcase
        end
    end

    assign o_prog_req = (st == ST_REQ);
    assign o_busy     = (st != ST_IDLE);

endmodule

// ==== loader/bram_prog_port.sv ====
`timescale 1ns/1ps
`include "loader_cfg.svh"

module bram_prog_port (
    input  logic                     i_EMU_MCLK,
    input  logic                     i_EMU_INITRST,
    ioctl_if.port                    ioctl,
    input  logic                     i_load,
    output logic [`PROM_ADDR_W-1:0]  o_prom_addr,
    output logic [`LDR_DATA_W-1:0]   o_prom_data,
    output logic                     o_prom_wr,
    output loader_pkg::prom_sel_e    o_prom_sel
);

    loader_pkg::prom_sel_e sel_next;

    // sound program below 0x2000, wavetables of 256 bytes above
    always_comb begin
        if (!ioctl.addr[13]) begin
            sel_next = loader_pkg::PROM_SND;
        end else if (!ioctl.addr[8]) begin
            sel_next = loader_pkg::PROM_WAVE1;
        end else begin
            sel_next = loader_pkg::PROM_WAVE2;
        end
    end

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_load) begin
            o_prom_addr <= ioctl.addr[`PROM_ADDR_W-1:0];
            o_prom_data <= ioctl.data;
        end
    end

    // single-cycle write pulse, select only valid alongside it
    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST) begin
            o_prom_wr  <= 1'b0;
            o_prom_sel <= loader_pkg::PROM_NONE;
        end else begin
            o_prom_wr  <= i_load;
            o_prom_sel <= i_load ? sel_next : loader_pkg::PROM_NONE;
        end
    end

endmodule

// ==== design/dipsw_bank.sv ====
`timescale 1ns/1ps
`include "loader_cfg.svh"

module dipsw_bank (
    input  logic        i_EMU_MCLK,
    input  logic        i_EMU_INITRST,
    ioctl_if.port       ioctl,
    input  logic        i_load,
    output logic [7:0]  o_dipsw1,
    output logic [7:0]  o_dipsw2,
    output logic [7:0]  o_dipsw3,
    output logic [7:0]  o_core_config
);

    input_pkg::dipsw_sel_e sel;

    // load is only issued for selectors 0..3
    assign sel = input_pkg::dipsw_sel_e'(ioctl.addr[1:0]);

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST) begin
            o_dipsw1      <= `DIPSW1_DEF;
            o_dipsw2      <= `DIPSW2_DEF;
            o_dipsw3      <= `DIPSW3_DEF;
            o_core_config <= `CORECFG_DEF;
        end else if (i_load) begin
            case (sel)
                input_pkg::DIP_SW1:     o_dipsw1      <= ioctl.data;
                input_pkg::DIP_SW2:     o_dipsw2      <= ioctl.data;
                input_pkg::DIP_SW3:     o_dipsw3      <= ioctl.data;
                input_pkg::DIP_CORECFG: o_core_config <= ioctl.data;
                default:                ;
            endcase
        end
    end

endmodule

// ==== design/input_mapper.sv ====
`timescale 1ns/1ps

module input_mapper (
    input  logic                   i_EMU_MCLK,
    input  logic                   i_EMU_INITRST,
    input  logic [15:0]            i_joystick0,
    input  logic [15:0]            i_joystick1,
    input  logic [7:0]             i_dipsw3,
    output input_pkg::board_in_t   o_board_in
);

    input_pkg::board_in_t in_next;

    // pad bits: 0 right, 1 left, 2 down, 3 up, 4/5 buttons, 7 select, 8 coin, 9 start
    always_comb begin
        // system byte, top three bits are switch bank 3
        in_next.in0 = {i_dipsw3[2:0], i_joystick1[9], i_joystick0[9],
                       i_joystick0[7], i_joystick1[8], i_joystick0[8]};

        // player 1, bit 7 carries the cabinet switch
        in_next.in1 = {i_dipsw3[3], 1'b1, i_joystick0[5], i_joystick0[4],
                       i_joystick0[2], i_joystick0[3], i_joystick0[0], i_joystick0[1]};

        // player 2
        in_next.in2 = {1'b1, 1'b1, i_joystick1[5], i_joystick1[4],
                       i_joystick1[2], i_joystick1[3], i_joystick1[0], i_joystick1[1]};
    end

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST) begin
            o_board_in <= '1;
        end else begin
            o_board_in <= in_next;
        end
    end

endmodule

// ==== design/rom_loader_top.sv ====
`timescale 1ns/1ps
`include "loader_cfg.svh"

module rom_loader_top (
    input  logic                     i_EMU_MCLK,
    input  logic                     i_EMU_INITRST,
    input  logic                     i_soft_rst,
    input  logic                     i_sdram_init,
    input  logic [`LDR_INDEX_W-1:0]  i_ioctl_index,
    input  logic [`LDR_ADDR_W-1:0]   i_ioctl_addr,
    input  logic [`LDR_DATA_W-1:0]   i_ioctl_data,
    input  logic                     i_ioctl_wr,
    input  logic                     i_prog_ack,
    input  logic [15:0]              i_joystick0,
    input  logic [15:0]              i_joystick1,
    output logic                     o_ioctl_wait,
    output logic                     o_prog_req,
    output logic [`SDR_ADDR_W-1:0]   o_prog_addr,
    output logic [`SDR_DATA_W-1:0]   o_prog_data,
    output logic [1:0]               o_prog_mask,
    output logic [1:0]               o_prog_bank,
    output logic [`PROM_ADDR_W-1:0]  o_prom_addr,
    output logic [`LDR_DATA_W-1:0]   o_prom_data,
    output logic                     o_prom_wr,
    output logic [2:0]               o_prom_sel,
    output logic [23:0]              o_board_in,
    output logic [7:0]               o_dipsw1,
    output logic [7:0]               o_dipsw2,
    output logic [7:0]               o_core_config,
    output logic                     o_game_rst
);

    logic                     sdram_load;
    logic                     prom_load;
    logic                     dip_load;
    logic                     sdram_busy;
    logic [7:0]               dipsw3;
    loader_pkg::sdram_prog_t  prog;
    loader_pkg::prom_sel_e    prom_sel;
    input_pkg::board_in_t     board_in;

    //////////////////////////////////////////////////
    // download bus

    ioctl_if ioctl ();

    assign ioctl.index = i_ioctl_index;
    assign ioctl.addr  = i_ioctl_addr;
    assign ioctl.data  = i_ioctl_data;
    assign ioctl.wr    = i_ioctl_wr;

    //////////////////////////////////////////////////
    // loader

    loader_ctrl u_ctrl (
        .i_EMU_MCLK    (i_EMU_MCLK),
        .i_EMU_INITRST (i_EMU_INITRST),
        .ioctl         (ioctl.ctrl),
        .i_soft_rst    (i_soft_rst),
        .i_sdram_init  (i_sdram_init),
        .i_sdram_busy  (sdram_busy),
        .o_sdram_load  (sdram_load),
        .o_prom_load   (prom_load),
        .o_dip_load    (dip_load),
        .o_ioctl_wait  (o_ioctl_wait),
        .o_game_rst    (o_game_rst)
    );

    sdram_prog_port u_sdram_port (
        .i_EMU_MCLK    (i_EMU_MCLK),
        .i_EMU_INITRST (i_EMU_INITRST),
        .ioctl         (ioctl.port),
        .i_load        (sdram_load),
        .i_prog_ack    (i_prog_ack),
        .o_prog        (prog),
        .o_prog_req    (o_prog_req),
        .o_busy        (sdram_busy)
    );

    bram_prog_port u_bram_port (
        .i_EMU_MCLK    (i_EMU_MCLK),
        .i_EMU_INITRST (i_EMU_INITRST),
        .ioctl         (ioctl.port),
        .i_load        (prom_load),
        .o_prom_addr   (o_prom_addr),
        .o_prom_data   (o_prom_data),
        .o_prom_wr     (o_prom_wr),
        .o_prom_sel    (prom_sel)
    );

    //////////////////////////////////////////////////
    // switches and inputs

    dipsw_bank u_dipsw (
        .i_EMU_MCLK    (i_EMU_MCLK),
        .i_EMU_INITRST (i_EMU_INITRST),
        .ioctl         (ioctl.port),
        .i_load        (dip_load),
        .o_dipsw1      (o_dipsw1),
        .o_dipsw2      (o_dipsw2),
        .o_dipsw3      (dipsw3),
        .o_core_config (o_core_config)
    );

    input_mapper u_inputs (
        .i_EMU_MCLK    (i_EMU_MCLK),
        .i_EMU_INITRST (i_EMU_INITRST),
        .i_joystick0   (i_joystick0),
        .i_joystick1   (i_joystick1),
        .i_dipsw3      (dipsw3),
        .o_board_in    (board_in)
    );

    // flatten structs onto the pins
    assign o_prog_addr = prog.addr;
    assign o_prog_data = prog.data;
    assign o_prog_mask = prog.mask;
    assign o_prog_bank = prog.bank;
    assign o_prom_sel  = prom_sel;
    assign o_board_in  = board_in;

endmodule

// ==== tests/rom_loader_assertions.sv ====
`timescale 1ns/1ps
`include "loader_cfg.svh"

module rom_loader_assertions (
    input logic                     i_EMU_MCLK,
    input logic                     i_EMU_INITRST,
    input logic                     i_soft_rst,
    input logic                     i_sdram_init,
    input logic [`LDR_INDEX_W-1:0]  i_ioctl_index,
    input logic [`LDR_ADDR_W-1:0]   i_ioctl_addr,
    input logic [`LDR_DATA_W-1:0]   i_ioctl_data,
    input logic                     i_ioctl_wr,
    input logic                     i_prog_ack,
    input logic [15:0]              i_joystick0,
    input logic [15:0]              i_joystick1,
    input logic [7:0]               i_dipsw3,
    input logic                     i_ioctl_wait,
    input logic                     i_prog_req,
    input logic [`SDR_ADDR_W-1:0]   i_prog_addr,
    input logic [`SDR_DATA_W-1:0]   i_prog_data,
    input logic [1:0]               i_prog_mask,
    input logic [1:0]               i_prog_bank,
    input logic [`PROM_ADDR_W-1:0]  i_prom_addr,
    input logic [`LDR_DATA_W-1:0]   i_prom_data,
    input logic                     i_prom_wr,
    input logic [2:0]               i_prom_sel,
    input logic [23:0]              i_board_in,
    input logic [7:0]               i_dipsw1,
    input logic [7:0]               i_dipsw2,
    input logic [7:0]               i_core_config,
    input logic                     i_game_rst
);

    // failed assertions so far
    int fail_count = 0;

    logic                     done_seen;
    logic                     accepted;
    logic                     rom_phase;
    logic                     sdr_hit;
    logic                     prom_hit;
    logic                     dip_hit;
    logic [3:0]               rgn;
    loader_pkg::sdram_prog_t  want_prog;
    loader_pkg::prom_sel_e    want_sel;
    logic [23:0]              want_in;
    logic [31:0]              sw_all;
    logic [31:0]              sw_next;

    function automatic logic [7:0] pad_byte(input logic [15:0] pad, input logic top);
        // left right up down, two buttons, spare, then top bit
        pad_byte = {top, 1'b1, pad[5], pad[4], pad[2], pad[3], pad[0], pad[1]};
    endfunction

    //////////////////////////////////////////////////
    // reference model of the download rules

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST) begin
            done_seen <= 1'b0;
        end else if (i_ioctl_index == `IDX_DIPSW) begin
            done_seen <= 1'b1;
        end
    end

    assign rgn       = i_ioctl_addr[19:16];
    assign accepted  = i_ioctl_wr & ~i_ioctl_wait;
    assign rom_phase = accepted & (i_ioctl_index == `IDX_ROM) & ~done_seen;
    assign sdr_hit   = rom_phase & (rgn < 4'd5);
    assign prom_hit  = rom_phase & (rgn == `REGION_PROM);
    assign dip_hit   = accepted & (i_ioctl_index == `IDX_DIPSW) & done_seen & ~i_ioctl_addr[2];
    assign sw_all    = {i_core_config, i_dipsw3, i_dipsw2, i_dipsw1};

    always_comb begin
        want_prog.data = {i_ioctl_data, i_ioctl_data};
        want_prog.bank = 2'd0;
        if (rgn == `REGION_BOOT) begin
            want_prog.addr = `BOOT_SDR_BASE + {7'd0, i_ioctl_addr[14:0]};
            want_prog.mask = {i_ioctl_addr[15], ~i_ioctl_addr[15]};
        end else begin
            want_prog.addr = {5'd0, i_ioctl_addr[16:0]};
            want_prog.mask = {i_ioctl_addr[17], ~i_ioctl_addr[17]};
        end
        // wave 2 in bit 2, wave 1 in bit 1, sound program in bit 0
        want_sel = loader_pkg::prom_sel_e'({i_ioctl_addr[13] & i_ioctl_addr[8],
                                            i_ioctl_addr[13] & ~i_ioctl_addr[8],
                                            ~i_ioctl_addr[13]});
        want_in  = {pad_byte(i_joystick1, 1'b1), pad_byte(i_joystick0, i_dipsw3[3]),
                    i_dipsw3[2:0], i_joystick1[9], i_joystick0[9], i_joystick0[7],
                    i_joystick1[8], i_joystick0[8]};
    end

    always_comb begin
        sw_next = sw_all;
        if (dip_hit) begin
            case (i_ioctl_addr[1:0])
                2'd0:    sw_next[7:0]   = i_ioctl_data;
                2'd1:    sw_next[15:8]  = i_ioctl_data;
                2'd2:    sw_next[23:16] = i_ioctl_data;
                default: sw_next[31:24] = i_ioctl_data;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // sdram program path

    a_sdr_map: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        sdr_hit |=> i_prog_req && i_ioctl_wait
            && {i_prog_addr, i_prog_data, i_prog_mask, i_prog_bank} == $past(want_prog))
        else begin
            $error("** Error %0t: sdram write mapped wrong", $time);
            fail_count++;
        end

    // no request without a mapped byte and none while ack is still up
    a_req_source: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        $rose(i_prog_req) |-> $past(sdr_hit) && !$past(i_prog_ack))
        else begin
            $error("** Error %0t: request rose without a valid write", $time);
            fail_count++;
        end

    a_req_hold: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        i_prog_req && !i_prog_ack |=> i_prog_req && $stable(i_prog_addr)
            && $stable(i_prog_data) && $stable(i_prog_mask) && $stable(i_prog_bank))
        else begin
            $error("** Error %0t: request dropped or payload moved before ack", $time);
            fail_count++;
        end

    a_req_drop: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        i_prog_req && i_prog_ack |=> !i_prog_req && i_ioctl_wait)
        else begin
            $error("** Error %0t: request not released after ack", $time);
            fail_count++;
        end

    a_ack_fall_wait: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        i_ioctl_wait && !i_prog_req && !i_sdram_init && i_prog_ack
            |=> i_ioctl_wait && !i_prog_req)
        else begin
            $error("** Error %0t: wait ended before ack fell", $time);
            fail_count++;
        end

    a_wait_release: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        i_ioctl_wait && !i_prog_req && !i_sdram_init && !i_prog_ack
            |=> !i_prog_req && (i_ioctl_wait == i_sdram_init))
        else begin
            $error("** Error %0t: wait held after ack fell", $time);
            fail_count++;
        end

    a_idle_wait: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        !i_prog_req && !i_ioctl_wait && !sdr_hit |=> !i_ioctl_wait || i_sdram_init)
        else begin
            $error("** Error %0t: wait rose with no sdram write", $time);
            fail_count++;
        end

    a_init_wait: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        i_sdram_init |-> i_ioctl_wait)
        else begin
            $error("** Error %0t: wait low during sdram init", $time);
            fail_count++;
        end

    //////////////////////////////////////////////////
    // prom, switches, inputs, reset

    a_prom_write: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        prom_hit |=> i_prom_wr && i_prom_addr == $past(i_ioctl_addr[13:0])
            && i_prom_data == $past(i_ioctl_data) && i_prom_sel == $past(want_sel))
        else begin
            $error("** Error %0t: prom write decoded wrong", $time);
            fail_count++;
        end

    a_prom_pulse: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        !prom_hit |=> !i_prom_wr && i_prom_sel == loader_pkg::PROM_NONE)
        else begin
            $error("** Error %0t: prom write pulse without a load", $time);
            fail_count++;
        end

    a_game_rst: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        i_game_rst == (~done_seen | i_soft_rst))
        else begin
            $error("** Error %0t: game reset level wrong", $time);
            fail_count++;
        end

    a_switch_update: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        1'b1 |=> sw_all == $past(sw_next))
        else begin
            $error("** Error %0t: switch bytes hold wrong values", $time);
            fail_count++;
        end

    a_board_in: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        1'b1 |=> i_board_in == $past(want_in))
        else begin
            $error("** Error %0t: board input bytes wrong", $time);
            fail_count++;
        end

    a_reset_state: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        $fell(i_EMU_INITRST) |-> !i_prog_req && !i_prom_wr
            && i_prom_sel == loader_pkg::PROM_NONE
            && i_game_rst && (i_ioctl_wait == i_sdram_init)
            && sw_all == {`CORECFG_DEF, `DIPSW3_DEF, `DIPSW2_DEF, `DIPSW1_DEF})
        else begin
            $error("** Error %0t: state after reset wrong", $time);
            fail_count++;
        end

endmodule

bind rom_loader_top rom_loader_assertions u_chk (
    .i_EMU_MCLK    (i_EMU_MCLK),
    .i_EMU_INITRST (i_EMU_INITRST),
    .i_soft_rst    (i_soft_rst),
    .i_sdram_init  (i_sdram_init),
    .i_ioctl_index (i_ioctl_index),
    .i_ioctl_addr  (i_ioctl_addr),
    .i_ioctl_data  (i_ioctl_data),
    .i_ioctl_wr    (i_ioctl_wr),
    .i_prog_ack    (i_prog_ack),
    .i_joystick0   (i_joystick0),
    .i_joystick1   (i_joystick1),
    .i_dipsw3      (dipsw3),
    .i_ioctl_wait  (o_ioctl_wait),
    .i_prog_req    (o_prog_req),
    .i_prog_addr   (o_prog_addr),
    .i_prog_data   (o_prog_data),
    .i_prog_mask   (o_prog_mask),
    .i_prog_bank   (o_prog_bank),
    .i_prom_addr   (o_prom_addr),
    .i_prom_data   (o_prom_data),
    .i_prom_wr     (o_prom_wr),
    .i_prom_sel    (o_prom_sel),
    .i_board_in    (o_board_in),
    .i_dipsw1      (o_dipsw1),
    .i_dipsw2      (o_dipsw2),
    .i_core_config (o_core_config),
    .i_game_rst    (o_game_rst)
);

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps
`include "loader_cfg.svh"

module tb_top;

    // six short tests, each well under 400 cycles
    localparam int MAX_CYCLES = 4000;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     soft_rst;
    logic                     sdram_init;
    logic [`LDR_INDEX_W-1:0]  ioctl_index;
    logic [`LDR_ADDR_W-1:0]   ioctl_addr;
    logic [`LDR_DATA_W-1:0]   ioctl_data;
    logic                     ioctl_wr;
    logic                     prog_ack = 1'b0;
    logic [15:0]              joy0;
    logic [15:0]              joy1;
    logic                     ioctl_wait;
    logic                     prog_req;
    logic [`SDR_ADDR_W-1:0]   prog_addr;
    logic [`SDR_DATA_W-1:0]   prog_data;
    logic [1:0]               prog_mask;
    logic [1:0]               prog_bank;
    logic [`PROM_ADDR_W-1:0]  prom_addr;
    logic [`LDR_DATA_W-1:0]   prom_data;
    logic                     prom_wr;
    logic [2:0]               prom_sel;
    logic [23:0]              board_in;
    logic [7:0]               dipsw1;
    logic [7:0]               dipsw2;
    logic [7:0]               core_config;
    logic                     game_rst;

    int cycles    = 0;
    int tb_errs   = 0;
    int errs_mark = 0;
    int passed    = 0;
    int failed    = 0;

    rom_loader_top dut (
        .i_EMU_MCLK    (clk),
        .i_EMU_INITRST (rst),
        .i_soft_rst    (soft_rst),
        .i_sdram_init  (sdram_init),
        .i_ioctl_index (ioctl_index),
        .i_ioctl_addr  (ioctl_addr),
        .i_ioctl_data  (ioctl_data),
        .i_ioctl_wr    (ioctl_wr),
        .i_prog_ack    (prog_ack),
        .i_joystick0   (joy0),
        .i_joystick1   (joy1),
        .o_ioctl_wait  (ioctl_wait),
        .o_prog_req    (prog_req),
        .o_prog_addr   (prog_addr),
        .o_prog_data   (prog_data),
        .o_prog_mask   (prog_mask),
        .o_prog_bank   (prog_bank),
        .o_prom_addr   (prom_addr),
        .o_prom_data   (prom_data),
        .o_prom_wr     (prom_wr),
        .o_prom_sel    (prom_sel),
        .o_board_in    (board_in),
        .o_dipsw1      (dipsw1),
        .o_dipsw2      (dipsw2),
        .o_core_config (core_config),
        .o_game_rst    (game_rst)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // sdram controller side, random delay at each phase

    always begin : ack_responder
        int unsigned gap;
        @(negedge clk);
        if (prog_req) begin
            gap = $urandom_range(5, 1);
            repeat (gap - 1) @(negedge clk);
            prog_ack = 1'b1;
            while (prog_req) @(negedge clk);
            gap = $urandom_range(5, 1);
            repeat (gap - 1) @(negedge clk);
            prog_ack = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped at the cycle limit of %0d", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus helpers

    // one byte on the download bus, held back while the loader stalls
    task automatic send_byte(input logic [15:0] idx, input logic [26:0] a,
                             input logic [7:0] d);
        int hold;
        hold = 0;
        while (ioctl_wait && hold < 100) begin
            @(negedge clk);
            hold++;
        end
        if (ioctl_wait) begin
            $display("the stream stayed stalled at %0t", $time);
            tb_errs++;
        end
        ioctl_index = idx;
        ioctl_addr  = a;
        ioctl_data  = d;
        ioctl_wr    = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
    endtask

    task automatic load_sdram_byte(input logic [26:0] a, input logic [7:0] d);
        int n;
        send_byte(`IDX_ROM, a, d);
        if (!prog_req) begin
            $display("the request never came at %0t", $time);
            tb_errs++;
        end
        n = 0;
        while (ioctl_wait && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (ioctl_wait) begin
            $display("the stream was never released at %0t", $time);
            tb_errs++;
        end
    endtask

    task automatic close_test(input string name);
        int total;
        repeat (3) @(negedge clk);
        total = dut.u_chk.fail_count + tb_errs;
        if (total == errs_mark) begin
            passed++;
            $display("%s: pass", name);
        end else begin
            failed++;
            $display("%s: FAIL, %0d new errors", name, total - errs_mark);
        end
        errs_mark = total;
    endtask

    //////////////////////////////////////////////////
    // test sequence

    initial begin
        logic [26:0] a;
        void'($urandom(32'h8e11a17a));
        rst         = 1'b1;
        soft_rst    = 1'b0;
        sdram_init  = 1'b0;
        ioctl_index = `IDX_ROM;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        joy0        = '0;
        joy1        = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);

        load_sdram_byte(27'h000_1234, 8'($urandom));
        load_sdram_byte(27'h002_8abc, 8'($urandom));
        load_sdram_byte(27'h001_0005, 8'($urandom));
        load_sdram_byte(27'h003_f00f, 8'($urandom));
        load_sdram_byte(27'h004_1234, 8'($urandom));
        load_sdram_byte(27'h004_9876, 8'($urandom));
        // region 6 goes nowhere
        send_byte(`IDX_ROM, 27'h006_0001, 8'h77);
        close_test("sdram map");

        repeat (10) begin
            a = 27'($urandom);
            a[19:16] = 4'($urandom_range(4, 0));
            load_sdram_byte(a, 8'($urandom));
        end
        close_test("handshake");

        send_byte(`IDX_ROM, 27'h005_0123, 8'($urandom));
        send_byte(`IDX_ROM, 27'h005_2045, 8'($urandom));
        send_byte(`IDX_ROM, 27'h005_2166, 8'($urandom));
        send_byte(`IDX_ROM, 27'h005_1fff, 8'($urandom));
        send_byte(`IDX_ROM, 27'h005_3eff, 8'($urandom));
        close_test("prom write");

        repeat (3) @(negedge clk);
        // first switch index ends the rom download
        send_byte(`IDX_DIPSW, 27'd0, 8'h5a);
        for (int i = 0; i < 8; i++) begin
            send_byte(`IDX_DIPSW, 27'(i), 8'($urandom));
        end
        send_byte(`IDX_ROM, 27'h000_0010, 8'h33);
        send_byte(`IDX_ROM, 27'h005_0010, 8'h44);
        soft_rst = 1'b1;
        repeat (2) @(negedge clk);
        soft_rst = 1'b0;
        close_test("switches");

        for (int i = 0; i < 24; i++) begin
            joy0 = 16'($urandom);
            joy1 = 16'($urandom);
            if (i == 12) begin
                send_byte(`IDX_DIPSW, 27'd2, 8'($urandom));
            end else begin
                @(negedge clk);
            end
        end
        close_test("board inputs");

        ioctl_index = `IDX_ROM;
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        sdram_init = 1'b1;
        repeat (6) @(negedge clk);
        sdram_init = 1'b0;
        load_sdram_byte(27'h000_0042, 8'($urandom));
        close_test("init and reset");

        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/loader_pkg.sv
common/input_pkg.sv
common/ioctl_if.sv
loader/loader_ctrl.sv
loader/sdram_prog_port.sv
loader/bram_prog_port.sv
design/dipsw_bank.sv
design/input_mapper.sv
design/rom_loader_top.sv
tests/rom_loader_assertions.sv
tests/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_top
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Mdir $(OBJ_DIR) --top-module $(TOP)
RUN_ARGS  := +verilator+error+limit+1000
PASS_MSG  := Done: no errors

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
